//--- all.f
+incdir+common
common/cpuPkg.sv
common/execBusIf.sv
src/registerFile.sv
src/execute/aluCore.sv
src/execute/decimalAdjust.sv
src/execute/statusReg.sv
src/datapath6502.sv
dv/tbClock.sv
dv/tbDatapath.sv

//--- Bender.yml
package:
  name: datapath6502

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpuPkg.sv
      - common/execBusIf.sv
      - src/registerFile.sv
      - src/execute/aluCore.sv
      - src/execute/decimalAdjust.sv
      - src/execute/statusReg.sv
      - src/datapath6502.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tbClock.sv
      - dv/tbDatapath.sv

//--- dv/tbDatapath.sv
/* datapath testbench: random microwords, reference model of
   A, X, Y, S and P, per-cycle compare and summary */
`default_nettype none
`include "cpu6502_config.svh"

module tbDatapath
  import cpuPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int EDGE_LIMIT = 100;
  localparam int RESET_LIMIT = 1000;
  localparam int DEC_COUNT = 20;

  logic       phi0;
  logic       arstN;
  logic       step;
  microWordU  microWord;
  logic [7:0] operand;
  logic [7:0] accum;
  logic [7:0] xReg;
  logic [7:0] yReg;
  logic [7:0] stackPtr;
  logic [7:0] status;

  // reference model state
  logic [7:0] mA;
  logic [7:0] mX;
  logic [7:0] mY;
  logic [7:0] mS;
  logic [7:0] mP;

  integer seed = 32'h1de9;
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int testErrBase = 0;
  int testCheckBase = 0;
  string curTest;

  // decimal words kept for the replay after CLD
  microWordU  decWords [DEC_COUNT];
  logic [7:0] decA [DEC_COUNT];
  logic [7:0] decB [DEC_COUNT];

  tbClock clkGen (.phi0(phi0), .arstN(arstN));

  datapath6502 DUT (
    .phi0     (phi0),
    .arstN    (arstN),
    .step     (step),
    .microWord(microWord),
    .operand  (operand),
    .accum    (accum),
    .xReg     (xReg),
    .yReg     (yReg),
    .stackPtr (stackPtr),
    .status   (status)
  );

  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  function automatic logic [7:0] regVal(input logic [2:0] sel, input logic [7:0] opnd);
    case (sel)
      `REG_A:  return mA;
      `REG_X:  return mX;
      `REG_Y:  return mY;
      `REG_S:  return mS;
      default: return opnd;
    endcase
  endfunction

  function automatic int fromBcd(input logic [7:0] b);
    return b[7:4] * 10 + b[3:0];
  endfunction

  function automatic logic [7:0] toBcd(input int n);
    return 8'(((n / 10) << 4) | (n % 10));
  endfunction

  function automatic microWordU makeAlu(input int op, input int sa, input int sb,
                                        input int inv, input int cinSel, input int dec,
                                        input int dst);
    microWordU w;
    w = '0;
    w.alu.kind      = 1'b1;
    w.alu.aluOp     = 3'(op);
    w.alu.srcA      = 3'(sa);
    w.alu.srcB      = 3'(sb);
    w.alu.invertB   = 1'(inv);
    w.alu.carryIn   = 2'(cinSel);
    w.alu.decimalEn = 1'(dec);
    w.alu.dest      = 2'(dst);
    return w;
  endfunction

  function automatic microWordU makeXfer(input int src, input int dst, input int wr,
                                         input int nz, input int fop);
    microWordU w;
    w = '0;
    w.xfer.src       = 3'(src);
    w.xfer.dest      = 2'(dst);
    w.xfer.writeDest = 1'(wr);
    w.xfer.updateNZ  = 1'(nz);
    w.xfer.flagOp    = 4'(fop);
    return w;
  endfunction

  task automatic writeReg(input logic [1:0] dst, input logic [7:0] v);
    case (dst)
      2'd0:    mA = v;
      2'd1:    mX = v;
      2'd2:    mY = v;
      default: mS = v;
    endcase
  endtask

  // one strobed word applied to the model
  task automatic modelStep(input microWordU w, input logic [7:0] opnd);
    logic [7:0] a;
    logic [7:0] bRaw;
    logic [7:0] b;
    logic [7:0] res;
    logic [7:0] v;
    logic       cin;
    int         total;
    int         sTotal;
    if (w.alu.kind) begin
      a    = regVal(w.alu.srcA, opnd);
      bRaw = regVal(w.alu.srcB, opnd);
      b    = w.alu.invertB ? ~bRaw : bRaw;
      case (w.alu.carryIn)
        `CIN_ONE:  cin = 1'b1;
        `CIN_FLAG: cin = mP[0];
        default:   cin = 1'b0;
      endcase
      res = a;
      case (w.alu.aluOp)
        `OP_SUM: begin
          total = int'(a) + int'(b) + int'(cin);
          sTotal = int'($signed(a)) + int'($signed(b)) + int'(cin);
          res = 8'(total);
          mP[0] = (total > 255);
          // signed sum outside the 8-bit range
          mP[6] = (sTotal > 127) || (sTotal < -128);
          // decimal: plain arithmetic on the two-digit values
          if (w.alu.decimalEn && mP[3] && !w.alu.invertB) begin
            total = fromBcd(a) + fromBcd(bRaw) + cin;
            mP[0] = (total > 99);
            res = toBcd(total % 100);
          end else if (w.alu.decimalEn && mP[3]) begin
            total = fromBcd(a) - fromBcd(bRaw) - (cin ? 0 : 1);
            res = toBcd(total < 0 ? total + 100 : total);
          end
        end
        `OP_AND: res = a & b;
        `OP_EOR: res = a ^ b;
        `OP_OR:  res = a | b;
        `OP_SR: begin
          res = {cin, a[7:1]};
          mP[0] = a[0];
        end
        default: ;
      endcase
      mP[7] = res[7];
      mP[1] = (res == 8'h00);
      writeReg(w.alu.dest, res);
    end else begin
      v = regVal(w.xfer.src, opnd);
      if (w.xfer.writeDest)
        writeReg(w.xfer.dest, v);
      if (w.xfer.updateNZ) begin
        mP[7] = v[7];
        mP[1] = (v == 8'h00);
      end
      case (w.xfer.flagOp)
        `FOP_SEC:   mP[0] = 1'b1;
        `FOP_CLC:   mP[0] = 1'b0;
        `FOP_SEI:   mP[2] = 1'b1;
        `FOP_CLI:   mP[2] = 1'b0;
        `FOP_SED:   mP[3] = 1'b1;
        `FOP_CLD:   mP[3] = 1'b0;
        `FOP_CLV:   mP[6] = 1'b0;
        `FOP_LOADP: mP = {v[7:6], 2'b10, v[3:0]};
        default: ;
      endcase
    end
  endtask

  task automatic checkValue(input string name, input logic [7:0] exp, input logic [7:0] act);
    checkCount++;
    if (exp !== act) begin
      errorCount++;
      $display("[ERROR] %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic checkAll();
    checkValue({curTest, " accum"}, mA, accum);
    checkValue({curTest, " xReg"}, mX, xReg);
    checkValue({curTest, " yReg"}, mY, yReg);
    checkValue({curTest, " stackPtr"}, mS, stackPtr);
    checkValue({curTest, " status"}, mP, status);
  endtask

  task automatic stopOnTimeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  // poll for a rising then a falling clock edge
  task automatic nextFall();
    int waited;
    waited = 0;
    while (phi0 !== 1'b1 && waited < EDGE_LIMIT) begin
      #1;
      waited++;
    end
    while (phi0 !== 1'b0 && waited < EDGE_LIMIT) begin
      #1;
      waited++;
    end
    if (waited >= EDGE_LIMIT)
      stopOnTimeout("a falling clock edge");
  endtask

  task automatic waitReset();
    int waited;
    waited = 0;
    while (arstN !== 1'b1 && waited < RESET_LIMIT) begin
      #1;
      waited++;
    end
    if (waited >= RESET_LIMIT)
      stopOnTimeout("reset release");
    nextFall();
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrBase = errorCount;
    testCheckBase = checkCount;
  endtask

  task automatic endTest();
    testCount++;
    $display("%s finished: %0d checks, %0d errors", curTest,
             checkCount - testCheckBase, errorCount - testErrBase);
  endtask

  // drive on the falling edge, compare on the next one
  task automatic doCycle(input microWordU w, input logic [7:0] opnd, input logic stb);
    microWord = w;
    operand = opnd;
    step = stb;
    if (stb)
      modelStep(w, opnd);
    nextFall();
    checkAll();
  endtask

  task automatic runTransfers();
    repeat (60)
      doCycle(makeXfer(pick(5), pick(4), pick(2), pick(2), `FOP_NONE), 8'(pick(256)),
              pick(4) != 0);
  endtask

  task automatic runBinary();
    repeat (80)
      doCycle(makeAlu(pick(5), pick(5), pick(5), pick(2), pick(3), pick(2), pick(4)),
              8'(pick(256)), 1'b1);
  endtask

  task automatic runDecimal();
    doCycle(makeXfer(`REG_IMM, 0, 0, 0, `FOP_SED), 8'h00, 1'b1);
    for (int i = 0; i < DEC_COUNT; i++) begin
      decA[i] = toBcd(pick(100));
      decB[i] = toBcd(pick(100));
      decWords[i] = makeAlu(`OP_SUM, `REG_A, `REG_IMM, pick(2), pick(3), 1, 0);
      doCycle(makeXfer(`REG_IMM, 0, 1, 0, `FOP_NONE), decA[i], 1'b1);
      doCycle(decWords[i], decB[i], 1'b1);
    end
    // same words again in binary mode
    doCycle(makeXfer(`REG_IMM, 0, 0, 0, `FOP_CLD), 8'h00, 1'b1);
    for (int i = 0; i < DEC_COUNT; i++) begin
      doCycle(makeXfer(`REG_IMM, 0, 1, 0, `FOP_NONE), decA[i], 1'b1);
      doCycle(decWords[i], decB[i], 1'b1);
    end
  endtask

  task automatic runFlags();
    repeat (60) begin
      doCycle(makeXfer(pick(5), pick(4), pick(2), pick(2), pick(9)), 8'(pick(256)), 1'b1);
      checkValue({curTest, " fixed bits"}, 8'h20, status & 8'h30);
    end
  endtask

  // every word reads A, so each one depends on the previous result
  task automatic runBackToBack();
    doCycle(makeXfer(`REG_IMM, 0, 0, 0, `FOP_CLD), 8'h00, 1'b1);
    repeat (60) begin
      if (pick(4) == 0)
        doCycle(makeXfer(`REG_A, pick(4), 1, 1, `FOP_NONE), 8'(pick(256)), 1'b1);
      else
        doCycle(makeAlu(pick(5), `REG_A, pick(5), pick(2), pick(3), 0, 0),
                8'(pick(256)), 1'b1);
    end
  endtask

  initial begin
    step = 1'b0;
    microWord = '0;
    operand = 8'h00;
    mA = 8'h00;
    mX = 8'h00;
    mY = 8'h00;
    mS = `SP_RESET;
    mP = 8'h24;
    waitReset();

    startTest("reset values");
    checkAll();
    endTest();
    startTest("transfers");
    runTransfers();
    endTest();
    startTest("binary alu");
    runBinary();
    endTest();
    startTest("decimal mode");
    runDecimal();
    endTest();
    startTest("flag operations");
    runFlags();
    endTest();
    startTest("back to back");
    runBackToBack();
    endTest();

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tbClock.sv
/* clock and reset source for the datapath testbench */
`default_nettype none

module tbClock (
  output logic phi0,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    phi0 = 1'b0;
    forever #20 phi0 = ~phi0;
  end

  // reset held for five rising edges, released on a falling edge
  initial begin
    arstN = 1'b0;
    repeat (5) @(posedge phi0);
    @(negedge phi0);
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- src/datapath6502.sv
/* execute datapath top: register file, ALU, decimal adjust and
   status register around the shared internal buses */
`default_nettype none

module datapath6502
  import cpuPkg::*;
(
  input  logic       phi0,
  input  logic       arstN,
  input  logic       step,
  input  microWordU  microWord,
  input  logic [7:0] operand,
  output logic [7:0] accum,
  output logic [7:0] xReg,
  output logic [7:0] yReg,
  output logic [7:0] stackPtr,
  output logic [7:0] status
);

  // binary ALU outputs into the decimal stage
  logic [7:0] binSum;
  logic       binCarry;
  logic       binOverflow;
  logic       halfCarry;

  // flags fed back from P
  logic       carryFlag;
  logic       decimalFlag;

  execBusIf busIf (.phi0(phi0));

  registerFile regFile (
    .phi0     (phi0),
    .arstN    (arstN),
    .step     (step),
    .microWord(microWord),
    .operand  (operand),
    .bus      (busIf.regs),
    .accum    (accum),
    .xReg     (xReg),
    .yReg     (yReg),
    .stackPtr (stackPtr)
  );

  aluCore alu (
    .bus        (busIf.exec),
    .microWord  (microWord),
    .carryFlag  (carryFlag),
    .binSum     (binSum),
    .binCarry   (binCarry),
    .binOverflow(binOverflow),
    .halfCarry  (halfCarry)
  );

  decimalAdjust decAdj (
    .bus        (busIf.exec),
    .microWord  (microWord),
    .decimalFlag(decimalFlag),
    .binSum     (binSum),
    .binCarry   (binCarry),
    .binOverflow(binOverflow),
    .halfCarry  (halfCarry)
  );

  statusReg pReg (
    .phi0       (phi0),
    .arstN      (arstN),
    .step       (step),
    .microWord  (microWord),
    .bus        (busIf.exec),
    .status     (status),
    .carryFlag  (carryFlag),
    .decimalFlag(decimalFlag)
  );

endmodule

`default_nettype wire

//--- src/execute/statusReg.sv
/* NV-BDIZC status register with ALU flag update, set/clear
   operations and P loads */
`default_nettype none
`include "cpu6502_config.svh"

module statusReg
  import cpuPkg::*;
(
  input  logic       phi0,
  input  logic       arstN,
  input  logic       step,
  input  microWordU  microWord,
  execBusIf.exec     bus,
  output logic [7:0] status,
  output logic       carryFlag,
  output logic       decimalFlag
);

  localparam logic [7:0] P_INIT = `P_RESET;

  logic       nFlag;
  logic       vFlag;
  logic       dFlag;
  logic       iFlag;
  logic       zFlag;
  logic       cFlag;
  logic [7:0] res;

  assign res = bus.result;

  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) begin
      nFlag <= P_INIT[7];
      vFlag <= P_INIT[6];
      dFlag <= P_INIT[3];
      iFlag <= P_INIT[2];
      zFlag <= P_INIT[1];
      cFlag <= P_INIT[0];
    end else if (step) begin
      if (microWord.alu.kind) begin
        nFlag <= res[7];
        zFlag <= (res == 8'h00);
        // logical ops keep C and V
        if (microWord.alu.aluOp == `OP_SUM || microWord.alu.aluOp == `OP_SR)
          cFlag <= bus.resultCarry;
        if (microWord.alu.aluOp == `OP_SUM)
          vFlag <= bus.resultOverflow;
      end else begin
        if (microWord.xfer.updateNZ) begin
          nFlag <= res[7];
          zFlag <= (res == 8'h00);
        end
        // flag op last, so a P load wins over the NZ update
        case (microWord.xfer.flagOp)
          `FOP_SEC: cFlag <= 1'b1;
          `FOP_CLC: cFlag <= 1'b0;
          `FOP_SEI: iFlag <= 1'b1;
          `FOP_CLI: iFlag <= 1'b0;
          `FOP_SED: dFlag <= 1'b1;
          `FOP_CLD: dFlag <= 1'b0;
          `FOP_CLV: vFlag <= 1'b0;
          `FOP_LOADP: {nFlag, vFlag, dFlag, iFlag, zFlag, cFlag} <=
                      {res[7:6], res[3:0]};
          default: ;
        endcase
      end
    end
  end

  // bit 5 reads 1, B reads 0
  assign status      = {nFlag, vFlag, 2'b10, dFlag, iFlag, zFlag, cFlag};
  assign carryFlag   = cFlag;
  assign decimalFlag = dFlag;

  // strobed transfer words carry a defined flag operation
  assert property (@(posedge phi0) disable iff (!arstN)
    (step && !microWord.xfer.kind) |-> (microWord.xfer.flagOp <= `FOP_LOADP));

endmodule

`default_nettype wire

//--- src/execute/decimalAdjust.sv
/* BCD correction of the binary sum and final result selection */
`default_nettype none
`include "cpu6502_config.svh"

module decimalAdjust
  import cpuPkg::*;
(
  execBusIf.exec    bus,
  input  microWordU microWord,
  input  logic      decimalFlag,
  input  logic [7:0] binSum,
  input  logic      binCarry,
  input  logic      binOverflow,
  input  logic      halfCarry
);

  logic       decMode;
  logic       loAdj;
  logic       hiAdj;
  logic [8:0] addStep;
  logic [7:0] addResult;
  logic [7:0] subResult;

  assign decMode = microWord.alu.kind && (microWord.alu.aluOp == `OP_SUM) &&
                   microWord.alu.decimalEn && decimalFlag;

  // add, low nibble first, then high nibble on the adjusted value
  assign loAdj = halfCarry || (binSum[3:0] > 4'd9);
  assign addStep = {1'b0, binSum} + (loAdj ? 9'h006 : 9'h000);
  assign hiAdj = binCarry || addStep[8] || (addStep[7:4] > 4'd9);
  assign addResult = addStep[7:0] + (hiAdj ? 8'h60 : 8'h00);

  // subtract, a missing nibble carry means that nibble borrowed
  assign subResult = binSum - (halfCarry ? 8'h00 : 8'h06) - (binCarry ? 8'h00 : 8'h60);

  always_comb begin
    if (!microWord.alu.kind) begin
      bus.result      = bus.sbBus;
      bus.resultCarry = binCarry;
    end else if (decMode && !microWord.alu.invertB) begin
      bus.result      = addResult;
      bus.resultCarry = hiAdj;
    end else if (decMode) begin
      bus.result      = subResult;
      bus.resultCarry = binCarry;
    end else begin
      bus.result      = binSum;
      bus.resultCarry = binCarry;
    end
  end

  // V is the binary overflow in every mode
  assign bus.resultOverflow = binOverflow;

endmodule

`default_nettype wire

//--- src/execute/aluCore.sv
/* binary ALU: sum, AND, EOR, OR and shift right with carry,
   overflow and half carry */
`default_nettype none
`include "cpu6502_config.svh"

module aluCore
  import cpuPkg::*;
(
  execBusIf.exec     bus,
  input  microWordU  microWord,
  input  logic       carryFlag,
  output logic [7:0] binSum,
  output logic       binCarry,
  output logic       binOverflow,
  output logic       halfCarry
);

  logic [7:0] opA;
  logic [7:0] opB;
  logic       cin;
  logic [8:0] fullSum;
  logic [4:0] lowSum;

  assign opA = bus.sbBus;
  // inverted B for subtract and compare
  assign opB = microWord.alu.invertB ? ~bus.dbBus : bus.dbBus;

  always_comb begin
    case (microWord.alu.carryIn)
      `CIN_ONE:  cin = 1'b1;
      `CIN_FLAG: cin = carryFlag;
      default:   cin = 1'b0;
    endcase
  end

  assign fullSum = {1'b0, opA} + {1'b0, opB} + {8'h00, cin};
  // carry out of the low nibble for the decimal stage
  assign lowSum = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'h0, cin};
  assign halfCarry = lowSum[4];

  always_comb begin
    binCarry    = carryFlag;
    binOverflow = 1'b0;
    case (microWord.alu.aluOp)
      `OP_SUM: begin
        binSum      = fullSum[7:0];
        binCarry    = fullSum[8];
        binOverflow = (opA[7] == opB[7]) && (fullSum[7] != opA[7]);
      end
      `OP_AND: binSum = opA & opB;
      `OP_EOR: binSum = opA ^ opB;
      `OP_OR:  binSum = opA | opB;
      `OP_SR: begin
        binSum   = {cin, opA[7:1]};
        binCarry = opA[0];
      end
      default: binSum = opA;
    endcase
  end

  // strobed ALU words carry one of the five operations
  assert property (@(posedge bus.phi0)
    (bus.writeEn && microWord.alu.kind) |->
      microWord.alu.aluOp inside {`OP_SUM, `OP_AND, `OP_EOR, `OP_OR, `OP_SR});

endmodule

`default_nettype wire

//--- src/registerFile.sv
/* A, X, Y and S registers with source bus selection and write-back */
`default_nettype none
`include "cpu6502_config.svh"

module registerFile
  import cpuPkg::*;
(
  input  logic       phi0,
  input  logic       arstN,
  input  logic       step,
  input  microWordU  microWord,
  input  logic [7:0] operand,
  execBusIf.regs     bus,
  output logic [7:0] accum,
  output logic [7:0] xReg,
  output logic [7:0] yReg,
  output logic [7:0] stackPtr
);

  // register or operand onto a bus
  function automatic logic [7:0] pickSource(
    input logic [2:0] sel,
    input logic [7:0] a,
    input logic [7:0] x,
    input logic [7:0] y,
    input logic [7:0] s,
    input logic [7:0] imm
  );
    case (sel)
      `REG_A:  return a;
      `REG_X:  return x;
      `REG_Y:  return y;
      `REG_S:  return s;
      default: return imm;
    endcase
  endfunction

  always_comb begin
    if (microWord.alu.kind) begin
      bus.sbBus    = pickSource(microWord.alu.srcA, accum, xReg, yReg, stackPtr, operand);
      bus.dbBus    = pickSource(microWord.alu.srcB, accum, xReg, yReg, stackPtr, operand);
      bus.writeSel = microWord.alu.dest;
      bus.writeEn  = step;
    end else begin
      // transfers only use the SB side
      bus.sbBus    = pickSource(microWord.xfer.src, accum, xReg, yReg, stackPtr, operand);
      bus.dbBus    = 8'h00;
      bus.writeSel = microWord.xfer.dest;
      bus.writeEn  = step & microWord.xfer.writeDest;
    end
  end

  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) begin
      accum    <= 8'h00;
      xReg     <= 8'h00;
      yReg     <= 8'h00;
      stackPtr <= `SP_RESET;
    end else if (bus.writeEn) begin
      case ({1'b0, bus.writeSel})
        `REG_A:  accum    <= bus.result;
        `REG_X:  xReg     <= bus.result;
        `REG_Y:  yReg     <= bus.result;
        default: stackPtr <= bus.result;
      endcase
    end
  end

  // strobed words select one of the five defined sources
  assert property (@(posedge phi0) disable iff (!arstN)
    step |-> (microWord.alu.kind ?
              (microWord.alu.srcA <= `REG_IMM) && (microWord.alu.srcB <= `REG_IMM) :
              (microWord.xfer.src <= `REG_IMM)));

endmodule

`default_nettype wire

//--- common/execBusIf.sv
/* internal source buses and execute results shared by the
   register file, ALU, decimal stage and status register */
`default_nettype none

interface execBusIf (
  input logic phi0
);

  // source buses, ALU inputs A and B
  logic [7:0] sbBus;
  logic [7:0] dbBus;

  // final execute result
  logic [7:0] result;
  logic       resultCarry;
  logic       resultOverflow;

  // write-back request
  logic       writeEn;
  logic [1:0] writeSel;

  modport regs (
    output sbBus, dbBus, writeEn, writeSel,
    input  result
  );

  modport exec (
    input  phi0, sbBus, dbBus, writeEn, writeSel,
    output result, resultCarry, resultOverflow
  );

endinterface

`default_nettype wire

//--- common/cpuPkg.sv
/* microword types: ALU form, transfer form and the union of both */
`default_nettype none

package cpuPkg;

  // ALU form, kind bit set
  typedef struct packed {
    logic       kind;
    logic [2:0] aluOp;
    logic [2:0] srcA;
    logic [2:0] srcB;
    logic       invertB;
    logic [1:0] carryIn;
    logic       decimalEn;
    logic [1:0] dest;
  } aluWordT;

  // transfer form, kind bit clear
  typedef struct packed {
    logic       kind;
    logic [2:0] src;
    logic [1:0] dest;
    logic       writeDest;
    logic       updateNZ;
    logic [3:0] flagOp;
    logic [3:0] spare;
  } xferWordT;

  // kind sits in bit 15 in both views, so either member can test it
  typedef union packed {
    aluWordT  alu;
    xferWordT xfer;
  } microWordU;

endpackage

`default_nettype wire

//--- common/cpu6502_config.svh
/* reset values, register select codes, ALU operation codes,
   carry-in choices and flag operation codes */
`ifndef CPU6502_CONFIG_SVH
`define CPU6502_CONFIG_SVH

// values after reset
`define SP_RESET 8'hFD
`define P_RESET 8'h24

// register selects, REG_IMM picks the operand input
`define REG_A 3'd0
`define REG_X 3'd1
`define REG_Y 3'd2
`define REG_S 3'd3
`define REG_IMM 3'd4

// ALU operations
`define OP_SUM 3'd0
`define OP_AND 3'd1
`define OP_EOR 3'd2
`define OP_OR 3'd3
`define OP_SR 3'd4

// carry-in source
`define CIN_ZERO 2'd0
`define CIN_ONE 2'd1
`define CIN_FLAG 2'd2

// flag operations of the transfer form
`define FOP_NONE 4'd0
`define FOP_SEC 4'd1
`define FOP_CLC 4'd2
`define FOP_SEI 4'd3
`define FOP_CLI 4'd4
`define FOP_SED 4'd5
`define FOP_CLD 4'd6
`define FOP_CLV 4'd7
`define FOP_LOADP 4'd8

`endif
